// ==== dv/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   force_refuse,
    input  mem_arbiter_pkg::bus_cmd_e              proc2mem_command,
    input  logic [mem_arbiter_pkg::xlen-1:0]       proc2mem_addr,
    input  logic [mem_arbiter_pkg::mem_data_w-1:0] proc2mem_data,
    output logic [mem_arbiter_pkg::mem_tag_w-1:0]  mem2proc_response,
    output logic [mem_arbiter_pkg::mem_data_w-1:0] mem2proc_data,
    output logic [mem_arbiter_pkg::mem_tag_w-1:0]  mem2proc_tag
);
    import mem_arbiter_pkg::*;

    // stored words, anything missing reads the fill pattern
    logic [mem_data_w-1:0] written [logic [xlen-1:0]];
    logic [31:0]           lcg_q;
    // refuse whatever shows up this cycle
    logic                  refuse_q;
    // next tag to hand out, 1 to 15
    logic [mem_tag_w-1:0]  tag_q;
    // cycles left before the load returns, zero when idle
    logic [2:0]            delay_q;
    logic [mem_tag_w-1:0]  ret_tag_q;
    logic [mem_data_w-1:0] ret_data_q;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [mem_data_w-1:0] read_word(input logic [xlen-1:0] addr);
        if (written.exists(addr)) begin
            return written[addr];
        end
        // address on top, its inverse below
        return {addr, ~addr};
    endfunction

    // accept in the same cycle the request is driven
    assign mem2proc_response = (proc2mem_command != bus_none && !refuse_q && !force_refuse)
                             ? tag_q : '0;

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            lcg_q         <= 32'h0b8c_9ec2;
            refuse_q      <= 1'b0;
            tag_q         <= 4'd1;
            delay_q       <= '0;
            ret_tag_q     <= '0;
            ret_data_q    <= '0;
            mem2proc_tag  <= '0;
            mem2proc_data <= '0;
        end else begin
            lcg_q        <= next_random(lcg_q);
            // about one cycle in four refused
            refuse_q     <= (lcg_q[31:30] == 2'b00);
            mem2proc_tag <= '0;
            if (mem2proc_response != '0) begin
                tag_q <= (tag_q == 4'd15) ? 4'd1 : tag_q + 4'd1;
                if (proc2mem_command == bus_store) begin
                    written[proc2mem_addr] = proc2mem_data;
                end else begin
                    delay_q    <= {1'b0, lcg_q[21:20]} + 3'd1;
                    ret_tag_q  <= tag_q;
                    ret_data_q <= read_word(proc2mem_addr);
                end
            end else if (delay_q != '0) begin
                delay_q <= delay_q - 3'd1;
                // tag and data together for one cycle
                if (delay_q == 3'd1) begin
                    mem2proc_tag  <= ret_tag_q;
                    mem2proc_data <= ret_data_q;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_arbiter;
    import mem_arbiter_pkg::*;

    typedef enum logic [2:0] {
        op_idle, op_fetch_on, op_fetch_off, op_redirect, op_load, op_store, op_refuse
    } op_e;

    typedef struct packed {
        op_e                   op;
        logic [xlen-1:0]       addr;
        logic [mem_data_w-1:0] wdata;
        logic [mem_data_w-1:0] load_value;
    } row_t;

    localparam int n_rows        = 15;
    localparam int idle_cycles   = 10;
    localparam int refuse_cycles = 6;
    localparam int wait_limit    = 200;

    ////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////

    // load values follow the fill rule or an earlier store
    row_t rows [n_rows] = '{
        '{op_idle,      32'h0000_0000, 64'h0, 64'h0},
        '{op_fetch_on,  32'h0000_0000, 64'h0, 64'h0},
        '{op_idle,      32'h0000_0000, 64'h0, 64'h0},
        '{op_load,      32'h0000_0100, 64'h0, 64'h0000_0100_ffff_feff},
        '{op_store,     32'h0000_8000, 64'hdead_beef_0123_4567, 64'h0},
        '{op_load,      32'h0000_8000, 64'h0, 64'hdead_beef_0123_4567},
        '{op_redirect,  32'h0000_1000, 64'h0, 64'h0},
        '{op_load,      32'h0000_8008, 64'h0, 64'h0000_8008_ffff_7ff7},
        '{op_redirect,  32'h0000_0400, 64'h0, 64'h0},
        '{op_store,     32'h0000_8010, 64'h0f1e_2d3c_4b5a_6978, 64'h0},
        '{op_load,      32'h0000_8010, 64'h0, 64'h0f1e_2d3c_4b5a_6978},
        '{op_fetch_off, 32'h0000_0000, 64'h0, 64'h0},
        '{op_idle,      32'h0000_0000, 64'h0, 64'h0},
        '{op_refuse,    32'h0000_0200, 64'h0, 64'h0000_0200_ffff_fdff},
        '{op_idle,      32'h0000_0000, 64'h0, 64'h0}
    };

    logic                  clock;
    logic                  reset;
    logic                  fetch_enable;
    logic                  take_branch;
    logic [xlen-1:0]       branch_target;
    bus_cmd_e              data_command;
    logic [xlen-1:0]       data_addr;
    logic [mem_data_w-1:0] data_wdata;
    logic                  force_refuse;
    logic [mem_tag_w-1:0]  mem2proc_response;
    logic [mem_data_w-1:0] mem2proc_data;
    logic [mem_tag_w-1:0]  mem2proc_tag;
    bus_cmd_e              proc2mem_command;
    logic [xlen-1:0]       proc2mem_addr;
    logic [mem_data_w-1:0] proc2mem_data;
    logic                  inst_valid;
    logic [xlen-1:0]       inst_addr;
    logic [mem_data_w-1:0] inst_data;
    logic                  load_valid;
    logic [mem_data_w-1:0] load_data;
    logic                  data_stall;

    int                    errors;
    int                    timeouts;
    int                    fetch_count;
    // fetches seen while a data load is open
    int                    inst_in_load;
    logic [xlen-1:0]       expected_pc;
    logic                  load_open;
    logic                  redirect_open;

    mem_arbiter_top dut (
        .clock (clock), .reset (reset),
        .fetch_enable (fetch_enable), .take_branch (take_branch),
        .branch_target (branch_target),
        .data_command (data_command), .data_addr (data_addr), .data_wdata (data_wdata),
        .mem2proc_response (mem2proc_response), .mem2proc_data (mem2proc_data),
        .mem2proc_tag (mem2proc_tag),
        .proc2mem_command (proc2mem_command), .proc2mem_addr (proc2mem_addr),
        .proc2mem_data (proc2mem_data),
        .inst_valid (inst_valid), .inst_addr (inst_addr), .inst_data (inst_data),
        .load_valid (load_valid), .load_data (load_data), .data_stall (data_stall)
    );

    mem_model u_mem (
        .clock (clock), .reset (reset), .force_refuse (force_refuse),
        .proc2mem_command (proc2mem_command), .proc2mem_addr (proc2mem_addr),
        .proc2mem_data (proc2mem_data),
        .mem2proc_response (mem2proc_response), .mem2proc_data (mem2proc_data),
        .mem2proc_tag (mem2proc_tag)
    );

    always #20 clock = ~clock;

    ////////////////////////////////////////////////////////////////////
    // return monitor
    ////////////////////////////////////////////////////////////////////

    // sample just after the edge once outputs settle
    always @(posedge clock) begin
        #1;
        if (!reset && inst_valid) begin
            if (inst_addr !== expected_pc) begin
                $display("ERROR inst_addr: got %h expected %h", inst_addr, expected_pc);
                errors++;
            end
            if (inst_data !== {expected_pc, ~expected_pc}) begin
                $display("ERROR inst_data: got %h expected %h", inst_data,
                         {expected_pc, ~expected_pc});
                errors++;
            end
            // only the fetch already in flight may finish first
            if (load_open) begin
                inst_in_load++;
                if (inst_in_load > 1) begin
                    $display("fetch returned ahead of a pending data load");
                    errors++;
                end
            end
            fetch_count++;
            redirect_open = 1'b0;
            expected_pc   = expected_pc + fetch_step;
        end
        if (!reset && load_valid && !load_open) begin
            $display("load_valid pulsed with no load outstanding");
            errors++;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // data port tasks
    ////////////////////////////////////////////////////////////////////

    task automatic wait_stall_clear;
        int cycles;
        cycles = 0;
        while (data_stall && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (data_stall) begin
            $display("timed out waiting for data_stall to drop");
            timeouts++;
        end
    endtask

    // one-cycle strobe that never lands while stalled
    task automatic strobe_data(input bus_cmd_e cmd, input logic [xlen-1:0] addr,
                               input logic [mem_data_w-1:0] wdata);
        wait_stall_clear();
        if (!data_stall) begin
            data_command = cmd;
            data_addr    = addr;
            data_wdata   = wdata;
            load_open    = (cmd == bus_load);
            inst_in_load = 0;
        end
        @(negedge clock);
        data_command = bus_none;
    endtask

    task automatic await_load(input logic [mem_data_w-1:0] value);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < wait_limit) begin
            if (load_valid) begin
                got = 1'b1;
                if (load_data !== value) begin
                    $display("ERROR load_data: got %h expected %h", load_data, value);
                    errors++;
                end
                // owner_data is left on the edge that raises load_valid
                if (data_stall !== 1'b0) begin
                    $display("ERROR data_stall: got %h expected %h", data_stall, 1'b0);
                    errors++;
                end
            end else begin
                // stall holds until the load is home
                if (data_stall !== 1'b1) begin
                    $display("ERROR data_stall: got %h expected %h", data_stall, 1'b1);
                    errors++;
                end
                @(negedge clock);
                cycles++;
            end
        end
        if (!got) begin
            $display("timed out waiting for load_valid");
            timeouts++;
        end
        load_open = 1'b0;
    endtask

    task automatic redirect_fetch(input logic [xlen-1:0] target);
        int cycles;
        take_branch   = 1'b1;
        branch_target = target;
        expected_pc   = target;
        redirect_open = 1'b1;
        @(negedge clock);
        take_branch = 1'b0;
        cycles = 0;
        while (redirect_open && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (redirect_open) begin
            $display("timed out waiting for a fetch at the branch target");
            timeouts++;
        end
    endtask

    // request must sit on the bus unchanged while memory refuses
    task automatic refused_load(input logic [xlen-1:0] addr, input logic [mem_data_w-1:0] value);
        force_refuse = 1'b1;
        strobe_data(bus_load, addr, '0);
        repeat (refuse_cycles) begin
            if (proc2mem_command !== bus_load) begin
                $display("ERROR proc2mem_command: got %h expected %h", proc2mem_command,
                         bus_load);
                errors++;
            end
            if (proc2mem_addr !== addr) begin
                $display("ERROR proc2mem_addr: got %h expected %h", proc2mem_addr, addr);
                errors++;
            end
            if (inst_valid !== 1'b0) begin
                $display("ERROR inst_valid: got %h expected %h", inst_valid, 1'b0);
                errors++;
            end
            if (load_valid !== 1'b0) begin
                $display("ERROR load_valid: got %h expected %h", load_valid, 1'b0);
                errors++;
            end
            @(negedge clock);
        end
        force_refuse = 1'b0;
        await_load(value);
    endtask

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        fetch_enable  = 1'b0;
        take_branch   = 1'b0;
        branch_target = '0;
        data_command  = bus_none;
        data_addr     = '0;
        data_wdata    = '0;
        force_refuse  = 1'b0;
        errors        = 0;
        timeouts      = 0;
        fetch_count   = 0;
        inst_in_load  = 0;
        expected_pc   = reset_pc;
        load_open     = 1'b0;
        redirect_open = 1'b0;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        // quiet bus out of reset
        if (proc2mem_command !== bus_none) begin
            $display("ERROR proc2mem_command: got %h expected %h", proc2mem_command,
                     bus_none);
            errors++;
        end
        if (data_stall !== 1'b0) begin
            $display("ERROR data_stall: got %h expected %h", data_stall, 1'b0);
            errors++;
        end
        if (inst_valid !== 1'b0) begin
            $display("ERROR inst_valid: got %h expected %h", inst_valid, 1'b0);
            errors++;
        end
        if (load_valid !== 1'b0) begin
            $display("ERROR load_valid: got %h expected %h", load_valid, 1'b0);
            errors++;
        end

        for (int i = 0; i < n_rows; i++) begin
            case (rows[i].op)
                op_idle:      repeat (idle_cycles) @(negedge clock);
                op_fetch_on:  fetch_enable = 1'b1;
                op_fetch_off: fetch_enable = 1'b0;
                op_redirect:  redirect_fetch(rows[i].addr);
                op_load: begin
                    strobe_data(bus_load, rows[i].addr, '0);
                    await_load(rows[i].load_value);
                end
                op_store: begin
                    strobe_data(bus_store, rows[i].addr, rows[i].wdata);
                    wait_stall_clear();
                end
                op_refuse:    refused_load(rows[i].addr, rows[i].load_value);
                default:      @(negedge clock);
            endcase
        end

        if (fetch_count < 4) begin
            $display("too few fetches returned while fetch was enabled");
            errors++;
        end

        $display("errors %0d, timeouts %0d, fetches %0d", errors, timeouts, fetch_count);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/mem_arbiter_pkg.sv
hdl/bus_owner_fsm.sv
hdl/fetch_pc_counter.sv
hdl/data_request_latch.sv
hdl/response_router.sv
hdl/mem_arbiter_top.sv
dv/mem_model.sv
dv/tb_mem_arbiter.sv

// ==== hdl/bus_owner_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_owner_fsm (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  fetch_enable,
    input  logic                                  take_branch,
    input  logic                                  data_pending,
    input  logic                                  data_is_store,
    input  logic [mem_arbiter_pkg::mem_tag_w-1:0] mem2proc_response,
    input  logic [mem_arbiter_pkg::mem_tag_w-1:0] mem2proc_tag,
    output mem_arbiter_pkg::owner_e               owner,
    output logic                                  issue_inst,
    output logic                                  issue_data,
    output logic                                  accept_inst,
    output logic                                  accept_data,
    output logic                                  ret_inst,
    output logic                                  ret_data
);
    import mem_arbiter_pkg::*;

    // tag handed back by memory at acceptance
    logic [mem_tag_w-1:0] tag_q;
    // fetch in flight was overtaken by a redirect
    logic                 drop_q;
    // nonzero response, memory took the request
    logic                 bus_accepts;
    // returning tag belongs to the outstanding request
    logic                 tag_hit;

    ////////////////////////////////////////////////////////////////////
    // issue and acceptance
    ////////////////////////////////////////////////////////////////////

    assign bus_accepts = (mem2proc_response != '0);

    // data port wins when both want the bus
    assign issue_data = (owner == owner_none) && data_pending;
    assign issue_inst = (owner == owner_none) && !data_pending && fetch_enable;

    // zero response leaves the issue standing for next cycle
    assign accept_data = issue_data && bus_accepts;
    assign accept_inst = issue_inst && bus_accepts;

    ////////////////////////////////////////////////////////////////////
    // return decode
    ////////////////////////////////////////////////////////////////////

    // tag_q is nonzero in any owner state, so tag zero never hits
    assign tag_hit = (owner != owner_none) && (mem2proc_tag == tag_q);

    // stale fetch: redirect seen at accept, in flight, or right now
    assign ret_inst = tag_hit && (owner == owner_inst) && !drop_q && !take_branch;
    assign ret_data = tag_hit && (owner == owner_data);

    ////////////////////////////////////////////////////////////////////
    // ownership state
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owner  <= owner_none;
            tag_q  <= '0;
            drop_q <= 1'b0;
        end else begin
            case (owner)
                owner_none: begin
                    // store expects no tag, stay idle
                    if (accept_data && !data_is_store) begin
                        owner <= owner_data;
                        tag_q <= mem2proc_response;
                    end else if (accept_inst) begin
                        owner  <= owner_inst;
                        tag_q  <= mem2proc_response;
                        drop_q <= take_branch;
                    end
                end
                owner_inst: begin
                    if (tag_hit) begin
                        owner  <= owner_none;
                        tag_q  <= '0;
                        drop_q <= 1'b0;
                    end else if (take_branch) begin
                        drop_q <= 1'b1;
                    end
                end
                owner_data: begin
                    if (tag_hit) begin
                        owner <= owner_none;
                        tag_q <= '0;
                    end
                end
                default: begin
                    owner <= owner_none;
                    tag_q <= '0;
                end
            endcase
        end
    end

    // an owned request always carries a real tag
    assert property (@(posedge clock) disable iff (reset)
        (owner != owner_none) |-> (tag_q != '0));

    // one requester per cycle on the bus
    assert property (@(posedge clock) disable iff (reset)
        !(issue_inst && issue_data));

endmodule

`default_nettype wire

// ==== hdl/data_request_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_request_latch (
    input  logic                                   clock,
    input  logic                                   reset,
    input  mem_arbiter_pkg::bus_cmd_e              data_command,
    input  logic [mem_arbiter_pkg::xlen-1:0]       data_addr,
    input  logic [mem_arbiter_pkg::mem_data_w-1:0] data_wdata,
    input  logic                                   accept_data,
    input  mem_arbiter_pkg::owner_e                owner,
    output logic                                   pending,
    output mem_arbiter_pkg::bus_cmd_e              pending_command,
    output logic [mem_arbiter_pkg::xlen-1:0]       pending_addr,
    output logic [mem_arbiter_pkg::mem_data_w-1:0] pending_wdata,
    output logic                                   data_stall
);
    import mem_arbiter_pkg::*;

    // one-cycle strobe from the data port
    logic strobe;

    assign strobe = (data_command != bus_none);

    ////////////////////////////////////////////////////////////////////
    // pending command
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending         <= 1'b0;
            pending_command <= bus_none;
        end else if (strobe) begin
            pending         <= 1'b1;
            pending_command <= data_command;
        end else if (accept_data) begin
            // memory has it, drop the hold
            pending         <= 1'b0;
        end
    end

    // address and store data ride along with the command
    always_ff @(posedge clock) begin
        if (strobe) begin
            pending_addr  <= data_addr;
            pending_wdata <= data_wdata;
        end
    end

    // stall from the strobe cycle until the load is home
    // store frees the port once accepted
    assign data_stall = strobe || pending || (owner == owner_data);

    // data port honours the stall
    assert property (@(posedge clock) disable iff (reset)
        strobe |-> (!pending && (owner != owner_data)));

endmodule

`default_nettype wire

// ==== hdl/fetch_pc_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_counter (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             accept_inst,
    input  logic                             take_branch,
    input  logic [mem_arbiter_pkg::xlen-1:0] branch_target,
    output logic [mem_arbiter_pkg::xlen-1:0] fetch_addr
);
    import mem_arbiter_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // fetch address register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fetch_addr <= reset_pc;
        end else if (take_branch) begin
            // redirect beats the step
            fetch_addr <= branch_target;
        end else if (accept_inst) begin
            // one beat per accepted fetch
            fetch_addr <= fetch_addr + fetch_step;
        end
    end

    // alignment is kept as long as every redirect target is aligned
    assert property (@(posedge clock) disable iff (reset)
        ((fetch_addr % fetch_step) == 0)
        && !(take_branch && ((branch_target % fetch_step) != 0))
        |=> ((fetch_addr % fetch_step) == 0));

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter_pkg.sv ====
`default_nettype none

package mem_arbiter_pkg;

    ////////////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////////////

    // address width
    localparam int xlen       = 32;
    // memory bus data width
    localparam int mem_data_w = 64;
    // tag width, tag zero means none
    localparam int mem_tag_w  = 4;

    // bytes per fetch, one bus beat
    localparam logic [xlen-1:0] fetch_step = 8;
    // fetch address out of reset
    localparam logic [xlen-1:0] reset_pc   = '0;

    ////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////

    // memory bus command
    typedef enum logic [1:0] {
        bus_none  = 2'b00,
        bus_load  = 2'b01,
        bus_store = 2'b10
    } bus_cmd_e;

    // who holds the outstanding request
    typedef enum logic [1:0] {
        owner_none = 2'b00,
        owner_inst = 2'b01,
        owner_data = 2'b10
    } owner_e;

endpackage

`default_nettype wire

// ==== hdl/mem_arbiter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_top (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   fetch_enable,
    input  logic                                   take_branch,
    input  logic [mem_arbiter_pkg::xlen-1:0]       branch_target,
    input  mem_arbiter_pkg::bus_cmd_e              data_command,
    input  logic [mem_arbiter_pkg::xlen-1:0]       data_addr,
    input  logic [mem_arbiter_pkg::mem_data_w-1:0] data_wdata,
    input  logic [mem_arbiter_pkg::mem_tag_w-1:0]  mem2proc_response,
    input  logic [mem_arbiter_pkg::mem_data_w-1:0] mem2proc_data,
    input  logic [mem_arbiter_pkg::mem_tag_w-1:0]  mem2proc_tag,
    output mem_arbiter_pkg::bus_cmd_e              proc2mem_command,
    output logic [mem_arbiter_pkg::xlen-1:0]       proc2mem_addr,
    output logic [mem_arbiter_pkg::mem_data_w-1:0] proc2mem_data,
    output logic                                   inst_valid,
    output logic [mem_arbiter_pkg::xlen-1:0]       inst_addr,
    output logic [mem_arbiter_pkg::mem_data_w-1:0] inst_data,
    output logic                                   load_valid,
    output logic [mem_arbiter_pkg::mem_data_w-1:0] load_data,
    output logic                                   data_stall
);
    import mem_arbiter_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////////////////////////////////

    // ownership and decisions
    owner_e              owner;
    logic                issue_inst;
    logic                issue_data;
    logic                accept_inst;
    logic                accept_data;
    logic                ret_inst;
    logic                ret_data;

    // fetch side
    logic [xlen-1:0]       fetch_addr;

    // held data request
    logic                  pending;
    bus_cmd_e              pending_command;
    logic [xlen-1:0]       pending_addr;
    logic [mem_data_w-1:0] pending_wdata;

    ////////////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////////////

    bus_owner_fsm u_owner (
        .clock             (clock),
        .reset             (reset),
        .fetch_enable      (fetch_enable),
        .take_branch       (take_branch),
        .data_pending      (pending),
        .data_is_store     (pending_command == bus_store),
        .mem2proc_response (mem2proc_response),
        .mem2proc_tag      (mem2proc_tag),
        .owner             (owner),
        .issue_inst        (issue_inst),
        .issue_data        (issue_data),
        .accept_inst       (accept_inst),
        .accept_data       (accept_data),
        .ret_inst          (ret_inst),
        .ret_data          (ret_data)
    );

    fetch_pc_counter u_fetch_pc (
        .clock         (clock),
        .reset         (reset),
        .accept_inst   (accept_inst),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .fetch_addr    (fetch_addr)
    );

    data_request_latch u_data_req (
        .clock           (clock),
        .reset           (reset),
        .data_command    (data_command),
        .data_addr       (data_addr),
        .data_wdata      (data_wdata),
        .accept_data     (accept_data),
        .owner           (owner),
        .pending         (pending),
        .pending_command (pending_command),
        .pending_addr    (pending_addr),
        .pending_wdata   (pending_wdata),
        .data_stall      (data_stall)
    );

    response_router u_router (
        .clock            (clock),
        .reset            (reset),
        .issue_inst       (issue_inst),
        .issue_data       (issue_data),
        .accept_inst      (accept_inst),
        .ret_inst         (ret_inst),
        .ret_data         (ret_data),
        .fetch_addr       (fetch_addr),
        .pending_command  (pending_command),
        .pending_addr     (pending_addr),
        .pending_wdata    (pending_wdata),
        .mem2proc_data    (mem2proc_data),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .proc2mem_data    (proc2mem_data),
        .inst_valid       (inst_valid),
        .inst_addr        (inst_addr),
        .inst_data        (inst_data),
        .load_valid       (load_valid),
        .load_data        (load_data)
    );

endmodule

`default_nettype wire

// ==== hdl/response_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module response_router (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   issue_inst,
    input  logic                                   issue_data,
    input  logic                                   accept_inst,
    input  logic                                   ret_inst,
    input  logic                                   ret_data,
    input  logic [mem_arbiter_pkg::xlen-1:0]       fetch_addr,
    input  mem_arbiter_pkg::bus_cmd_e              pending_command,
    input  logic [mem_arbiter_pkg::xlen-1:0]       pending_addr,
    input  logic [mem_arbiter_pkg::mem_data_w-1:0] pending_wdata,
    input  logic [mem_arbiter_pkg::mem_data_w-1:0] mem2proc_data,
    output mem_arbiter_pkg::bus_cmd_e              proc2mem_command,
    output logic [mem_arbiter_pkg::xlen-1:0]       proc2mem_addr,
    output logic [mem_arbiter_pkg::mem_data_w-1:0] proc2mem_data,
    output logic                                   inst_valid,
    output logic [mem_arbiter_pkg::xlen-1:0]       inst_addr,
    output logic [mem_arbiter_pkg::mem_data_w-1:0] inst_data,
    output logic                                   load_valid,
    output logic [mem_arbiter_pkg::mem_data_w-1:0] load_data
);
    import mem_arbiter_pkg::*;

    // address of the fetch in flight
    logic [xlen-1:0] flight_addr;

    ////////////////////////////////////////////////////////////////////
    // request mux
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        proc2mem_command = bus_none;
        proc2mem_addr    = '0;
        proc2mem_data    = '0;
        if (issue_data) begin
            proc2mem_command = pending_command;
            proc2mem_addr    = pending_addr;
            proc2mem_data    = pending_wdata;
        end else if (issue_inst) begin
            // fetch is always a full-beat load
            proc2mem_command = bus_load;
            proc2mem_addr    = fetch_addr;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // returns
    ////////////////////////////////////////////////////////////////////

    // counter moves on after accept, keep the old address
    always_ff @(posedge clock) begin
        if (accept_inst) begin
            flight_addr <= fetch_addr;
        end
    end

    // valid pulses, one cycle each
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            inst_valid <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            inst_valid <= ret_inst;
            load_valid <= ret_data;
        end
    end

    // data goes only to the port that owns the tag
    always_ff @(posedge clock) begin
        if (ret_inst) begin
            inst_addr <= flight_addr;
            inst_data <= mem2proc_data;
        end
        if (ret_data) begin
            load_data <= mem2proc_data;
        end
    end

endmodule

`default_nettype wire
